// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
TOP       ?= ps2_host_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/ps2_bus_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_bus_regs (
    input  logic               PS2_CLK_i,
    input  logic               arst_n_i,
    input  logic               chipselect_i,
    input  logic               write_i,
    input  logic [1:0]         address_i,
    input  logic [31:0]        writedata_i,
    output logic [31:0]        readdata_o,
    output logic               waitrequest_n_o,
    output logic               irq_o,
    output logic               tx_start_o,
    output ps2_pkg::ps2_byte_t tx_byte_o,
    input  logic               tx_busy_i,
    input  logic               tx_done_i,
    input  logic               ack_ok_i,
    input  logic               rx_err_i,
    input  ps2_pkg::ps2_byte_t fifo_head_i,
    input  logic               fifo_not_empty_i,
    input  logic               fifo_overflow_i,
    output logic               fifo_pop_o
);
    import ps2_pkg::*;

    logic        access;
    logic        data_wr;
    logic        stall;
    logic        complete;
    logic        ack_err_q;
    logic        parity_err_q;
    logic        overflow_q;
    logic        irq_en_q;
    logic [31:0] status_w;

    // New access only when not already in the completion cycle
    assign access   = chipselect_i && !waitrequest_n_o;
    assign data_wr  = access && write_i && (address_i == REG_DATA);
    // Data writes wait for the transmitter, tx_start covers the gap before busy
    assign stall    = data_wr && (tx_busy_i || tx_start_o);
    assign complete = access && !stall;

    assign irq_o = irq_en_q && fifo_not_empty_i;

    always_comb begin
        status_w                  = '0;
        status_w[STAT_RX_VALID]   = fifo_not_empty_i;
        status_w[STAT_TX_BUSY]    = tx_busy_i;
        status_w[STAT_ACK_ERR]    = ack_err_q;
        status_w[STAT_PARITY_ERR] = parity_err_q;
        status_w[STAT_OVERFLOW]   = overflow_q;
    end

    ////////////////////////////////////////////////////////////
    // Handshake, strobes and control state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PS2_CLK_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            waitrequest_n_o <= 1'b0;
            tx_start_o      <= 1'b0;
            fifo_pop_o      <= 1'b0;
            irq_en_q        <= 1'b0;
            ack_err_q       <= 1'b0;
            parity_err_q    <= 1'b0;
            overflow_q      <= 1'b0;
        end else begin
            waitrequest_n_o <= complete;
            tx_start_o      <= complete && write_i && (address_i == REG_DATA);
            fifo_pop_o      <= complete && !write_i && (address_i == REG_DATA)
                               && fifo_not_empty_i;
            if (complete && write_i && address_i == REG_CONTROL) begin
                irq_en_q <= writedata_i[CTRL_IRQ_EN];
            end
            // Write-one-to-clear, a new event wins over the clear
            if (complete && write_i && address_i == REG_STATUS) begin
                ack_err_q    <= ack_err_q & ~writedata_i[STAT_ACK_ERR];
                parity_err_q <= parity_err_q & ~writedata_i[STAT_PARITY_ERR];
                overflow_q   <= overflow_q & ~writedata_i[STAT_OVERFLOW];
            end
            if (tx_done_i && !ack_ok_i) begin
                ack_err_q <= 1'b1;
            end
            if (rx_err_i) begin
                parity_err_q <= 1'b1;
            end
            if (fifo_overflow_i) begin
                overflow_q <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read data and transmit byte
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PS2_CLK_i) begin
        if (complete && !write_i) begin
            case (address_i)
                REG_DATA:    readdata_o <= fifo_not_empty_i ? 32'(fifo_head_i) : '0;
                REG_STATUS:  readdata_o <= status_w;
                REG_CONTROL: readdata_o <= 32'(irq_en_q);
                default:     readdata_o <= '0;
            endcase
        end
        if (complete && data_wr) begin
            tx_byte_o <= writedata_i[7:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/ps2_host_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_host_top #(
    parameter int INHIBIT_CYCLES = 5000,
    parameter int FILTER_LEN     = 8,
    parameter int FIFO_DEPTH     = 4
) (
    input  logic        PS2_CLK_i,
    input  logic        arst_n_i,
    input  logic        chipselect_i,
    input  logic        write_i,
    input  logic [1:0]  address_i,
    input  logic [31:0] writedata_i,
    output logic [31:0] readdata_o,
    output logic        waitrequest_n_o,
    output logic        irq_o,
    input  logic        kbd_clk_i,
    input  logic        kbd_dat_i,
    output logic        kbd_clk_oe_o,
    output logic        kbd_dat_oe_o
);
    import ps2_pkg::*;

    logic      clk_fall;
    logic      dat_level;
    ps2_byte_t rx_byte;
    logic      rx_strobe;
    logic      rx_err;
    ps2_byte_t fifo_head;
    logic      fifo_not_empty;
    logic      fifo_overflow;
    logic      fifo_pop;
    ps2_byte_t tx_byte;
    logic      tx_start;
    logic      tx_busy;
    logic      tx_done;
    logic      ack_ok;

    ////////////////////////////////////////////////////////////
    // Line conditioning
    ////////////////////////////////////////////////////////////

    // Only the falling edge of the clock line is used
    ps2_line_sync #(.FILTER_LEN(FILTER_LEN)) u_clk_sync (
        .PS2_CLK_i (PS2_CLK_i),
        .arst_n_i  (arst_n_i),
        .line_i    (kbd_clk_i),
        .level_o   (),
        .fall_o    (clk_fall)
    );

    // Only the level of the data line matters
    ps2_line_sync #(.FILTER_LEN(FILTER_LEN)) u_dat_sync (
        .PS2_CLK_i (PS2_CLK_i),
        .arst_n_i  (arst_n_i),
        .line_i    (kbd_dat_i),
        .level_o   (dat_level),
        .fall_o    ()
    );

    ////////////////////////////////////////////////////////////
    // Engines, queue and register block
    ////////////////////////////////////////////////////////////

    ps2_receiver u_rx (
        .PS2_CLK_i   (PS2_CLK_i),
        .arst_n_i    (arst_n_i),
        .enable_i    (~tx_busy),
        .clk_fall_i  (clk_fall),
        .dat_level_i (dat_level),
        .rx_byte_o   (rx_byte),
        .rx_strobe_o (rx_strobe),
        .rx_err_o    (rx_err)
    );

    ps2_transmitter #(.INHIBIT_CYCLES(INHIBIT_CYCLES)) u_tx (
        .PS2_CLK_i   (PS2_CLK_i),
        .arst_n_i    (arst_n_i),
        .tx_start_i  (tx_start),
        .tx_byte_i   (tx_byte),
        .clk_fall_i  (clk_fall),
        .dat_level_i (dat_level),
        .clk_oe_o    (kbd_clk_oe_o),
        .dat_oe_o    (kbd_dat_oe_o),
        .tx_busy_o   (tx_busy),
        .tx_done_o   (tx_done),
        .ack_ok_o    (ack_ok)
    );

    ps2_rx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .PS2_CLK_i   (PS2_CLK_i),
        .arst_n_i    (arst_n_i),
        .push_i      (rx_strobe),
        .push_data_i (rx_byte),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .not_empty_o (fifo_not_empty),
        .overflow_o  (fifo_overflow)
    );

    ps2_bus_regs u_regs (
        .PS2_CLK_i        (PS2_CLK_i),
        .arst_n_i         (arst_n_i),
        .chipselect_i     (chipselect_i),
        .write_i          (write_i),
        .address_i        (address_i),
        .writedata_i      (writedata_i),
        .readdata_o       (readdata_o),
        .waitrequest_n_o  (waitrequest_n_o),
        .irq_o            (irq_o),
        .tx_start_o       (tx_start),
        .tx_byte_o        (tx_byte),
        .tx_busy_i        (tx_busy),
        .tx_done_i        (tx_done),
        .ack_ok_i         (ack_ok),
        .rx_err_i         (rx_err),
        .fifo_head_i      (fifo_head),
        .fifo_not_empty_i (fifo_not_empty),
        .fifo_overflow_i  (fifo_overflow),
        .fifo_pop_o       (fifo_pop)
    );

endmodule

`default_nettype wire

// ==== design/ps2_line_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_line_sync #(
    parameter int FILTER_LEN = 8
) (
    input  logic PS2_CLK_i,
    input  logic arst_n_i,
    input  logic line_i,
    output logic level_o,
    output logic fall_o
);

    localparam int CNT_W = $clog2(FILTER_LEN + 1);

    logic             meta_q;
    logic             sync_q;
    logic [CNT_W-1:0] cnt_q;

    // Idle PS/2 lines float high, so filter starts high
    always_ff @(posedge PS2_CLK_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            meta_q  <= 1'b1;
            sync_q  <= 1'b1;
            cnt_q   <= '0;
            level_o <= 1'b1;
            fall_o  <= 1'b0;
        end else begin
            meta_q <= line_i;
            sync_q <= meta_q;
            fall_o <= 1'b0;
            if (sync_q == level_o) begin
                cnt_q <= '0;
            end else if (cnt_q == CNT_W'(FILTER_LEN - 1)) begin
                // Enough matching samples, accept new level
                level_o <= sync_q;
                fall_o  <= level_o;
                cnt_q   <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/ps2_pkg.sv ====
`default_nettype none

package ps2_pkg;

    ////////////////////////////////////////////////////////////
    // Data and register map
    ////////////////////////////////////////////////////////////

    typedef logic [7:0] ps2_byte_t;

    // Word addresses on the slave bus
    localparam logic [1:0] REG_DATA    = 2'd0;
    localparam logic [1:0] REG_STATUS  = 2'd1;
    localparam logic [1:0] REG_CONTROL = 2'd2;

    // Status word bits
    localparam int STAT_RX_VALID   = 0;
    localparam int STAT_TX_BUSY    = 1;
    localparam int STAT_ACK_ERR    = 2;
    localparam int STAT_PARITY_ERR = 3;
    localparam int STAT_OVERFLOW   = 4;

    // Control word bits
    localparam int CTRL_IRQ_EN = 0;

    // Odd parity: bit makes total count of ones odd
    function automatic logic ps2_odd_parity(input ps2_byte_t data);
        return ~(^data);
    endfunction

endpackage

`default_nettype wire

// ==== design/ps2_receiver.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_receiver (
    input  logic               PS2_CLK_i,
    input  logic               arst_n_i,
    input  logic               enable_i,
    input  logic               clk_fall_i,
    input  logic               dat_level_i,
    output ps2_pkg::ps2_byte_t rx_byte_o,
    output logic               rx_strobe_o,
    output logic               rx_err_o
);
    import ps2_pkg::*;

    // shift_q[0] start, [8:1] data, [9] parity once ten bits are in
    logic [9:0] shift_q;
    logic [3:0] bit_cnt_q;
    logic       last_bit;
    logic       parity_ok;
    logic       stop_ok;

    assign last_bit  = (bit_cnt_q == 4'd10);
    assign parity_ok = (shift_q[9] == ps2_odd_parity(shift_q[8:1]));
    assign stop_ok   = dat_level_i;

    ////////////////////////////////////////////////////////////
    // Bit counter and frame check
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PS2_CLK_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bit_cnt_q   <= '0;
            rx_strobe_o <= 1'b0;
            rx_err_o    <= 1'b0;
        end else begin
            rx_strobe_o <= 1'b0;
            rx_err_o    <= 1'b0;
            if (!enable_i) begin
                // Host owns the bus, drop any partial frame
                bit_cnt_q <= '0;
            end else if (clk_fall_i) begin
                if (last_bit) begin
                    bit_cnt_q <= '0;
                    if (parity_ok && stop_ok) begin
                        rx_strobe_o <= 1'b1;
                    end else begin
                        rx_err_o <= 1'b1;
                    end
                end else if (bit_cnt_q == 4'd0 && dat_level_i) begin
                    // No start bit, stay idle
                    bit_cnt_q <= '0;
                end else begin
                    bit_cnt_q <= bit_cnt_q + 4'd1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Payload capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PS2_CLK_i) begin
        if (enable_i && clk_fall_i) begin
            shift_q <= {dat_level_i, shift_q[9:1]};
            if (last_bit) begin
                rx_byte_o <= shift_q[8:1];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/ps2_rx_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_rx_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               PS2_CLK_i,
    input  logic               arst_n_i,
    input  logic               push_i,
    input  ps2_pkg::ps2_byte_t push_data_i,
    input  logic               pop_i,
    output ps2_pkg::ps2_byte_t head_o,
    output logic               not_empty_o,
    output logic               overflow_o
);
    import ps2_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    ps2_byte_t     mem_q [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic          full;
    logic          do_pop;
    logic          do_push;

    assign full        = (count_q == (AW + 1)'(FIFO_DEPTH));
    assign not_empty_o = (count_q != '0);
    assign head_o      = mem_q[rd_ptr_q];
    assign do_pop      = pop_i && not_empty_o;
    // A pop in the same cycle frees the slot for a push
    assign do_push     = push_i && (!full || do_pop);

    always_ff @(posedge PS2_CLK_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            overflow_o <= push_i && !do_push;
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge PS2_CLK_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/ps2_transmitter.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_transmitter #(
    parameter int INHIBIT_CYCLES = 5000
) (
    input  logic               PS2_CLK_i,
    input  logic               arst_n_i,
    input  logic               tx_start_i,
    input  ps2_pkg::ps2_byte_t tx_byte_i,
    input  logic               clk_fall_i,
    input  logic               dat_level_i,
    output logic               clk_oe_o,
    output logic               dat_oe_o,
    output logic               tx_busy_o,
    output logic               tx_done_o,
    output logic               ack_ok_o
);
    import ps2_pkg::*;

    localparam int CNT_W = $clog2(INHIBIT_CYCLES + 16);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INHIBIT,
        ST_RTS,
        ST_SHIFT,
        ST_ACK,
        ST_FINISH
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] cnt_q;
    // {parity, data}, shifted out LSB first with ones behind it
    logic [8:0]       frame_q;

    assign tx_busy_o = (state_q != ST_IDLE);

    ////////////////////////////////////////////////////////////
    // Frame sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PS2_CLK_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            cnt_q     <= '0;
            clk_oe_o  <= 1'b0;
            dat_oe_o  <= 1'b0;
            tx_done_o <= 1'b0;
            ack_ok_o  <= 1'b0;
        end else begin
            tx_done_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (tx_start_i) begin
                        clk_oe_o <= 1'b1;
                        cnt_q    <= '0;
                        state_q  <= ST_INHIBIT;
                    end
                end
                ST_INHIBIT: begin
                    if (cnt_q == CNT_W'(INHIBIT_CYCLES - 1)) begin
                        // Request-to-send, data low under the held clock
                        dat_oe_o <= 1'b1;
                        state_q  <= ST_RTS;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_RTS: begin
                    clk_oe_o <= 1'b0;
                    cnt_q    <= '0;
                    state_q  <= ST_SHIFT;
                end
                ST_SHIFT: begin
                    // Ten falls: eight data bits, parity, stop release
                    if (clk_fall_i) begin
                        dat_oe_o <= ~frame_q[0];
                        if (cnt_q == CNT_W'(9)) begin
                            state_q <= ST_ACK;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                ST_ACK: begin
                    if (clk_fall_i) begin
                        ack_ok_o <= ~dat_level_i;
                        state_q  <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    // Device lets go of data once its clock is back high
                    if (dat_level_i) begin
                        tx_done_o <= 1'b1;
                        state_q   <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge PS2_CLK_i) begin
        if (state_q == ST_IDLE && tx_start_i) begin
            frame_q <= {ps2_odd_parity(tx_byte_i), tx_byte_i};
        end else if (state_q == ST_SHIFT && clk_fall_i) begin
            frame_q <= {1'b1, frame_q[8:1]};
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
design/ps2_pkg.sv
design/ps2_line_sync.sv
design/ps2_receiver.sv
design/ps2_transmitter.sv
design/ps2_rx_fifo.sv
design/ps2_bus_regs.sv
design/ps2_host_top.sv
sim/ps2_host_tb.sv

// ==== sim/ps2_host_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_host_tb;

    localparam int CLK_HALF_NS = 10;
    localparam int INHIBIT     = 200;
    localparam int RX_DEPTH    = 4;
    localparam int BIT_NS      = 4000;
    localparam int HALF_NS     = BIT_NS / 2;
    localparam int QUARTER_NS  = BIT_NS / 4;
    // One frame covers eleven bits, the inhibit time and some idle gap
    localparam int FRAME_NS    = 11 * BIT_NS + INHIBIT * 2 * CLK_HALF_NS + 2 * BIT_NS;
    localparam int WATCHDOG_NS = 40 * FRAME_NS + 100_000;

    // Register map and status bits
    localparam logic [1:0]  A_DATA  = 2'd0;
    localparam logic [1:0]  A_STAT  = 2'd1;
    localparam logic [1:0]  A_CTRL  = 2'd2;
    localparam logic [31:0] ST_RXV  = 32'h01;
    localparam logic [31:0] ST_BUSY = 32'h02;
    localparam logic [31:0] ST_ACK  = 32'h04;
    localparam logic [31:0] ST_PAR  = 32'h08;
    localparam logic [31:0] ST_OVF  = 32'h10;

    logic        sys_clk;
    logic        arst_n;
    logic        cs;
    logic        wr;
    logic [1:0]  addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        wrn;
    logic        irq;
    logic        clk_oe;
    logic        dat_oe;
    logic        dev_clk;
    logic        dev_dat;
    wire         kbd_clk;
    wire         kbd_dat;

    logic [31:0] rng_state;
    int          n_errors;
    int          n_checks;
    int          n_tests;

    // Open-collector lines where either side may pull low
    assign kbd_clk = dev_clk & ~clk_oe;
    assign kbd_dat = dev_dat & ~dat_oe;

    ps2_host_top #(
        .INHIBIT_CYCLES (INHIBIT),
        .FIFO_DEPTH     (RX_DEPTH)
    ) UUT (
        .PS2_CLK_i       (sys_clk),
        .arst_n_i        (arst_n),
        .chipselect_i    (cs),
        .write_i         (wr),
        .address_i       (addr),
        .writedata_i     (wdata),
        .readdata_o      (rdata),
        .waitrequest_n_o (wrn),
        .irq_o           (irq),
        .kbd_clk_i       (kbd_clk),
        .kbd_dat_i       (kbd_dat),
        .kbd_clk_oe_o    (clk_oe),
        .kbd_dat_oe_o    (dat_oe)
    );

    initial sys_clk = 1'b0;
    always #(CLK_HALF_NS) sys_clk = ~sys_clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [7:0] rand_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];
    endfunction

    // One when the byte holds an even number of ones
    function automatic logic parity_of(input logic [7:0] b);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                ones++;
            end
        end
        return (ones % 2 == 0);
    endfunction

    task automatic expect_eq(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_tests++;
        if (n_errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, n_errors - errs_before);
        end
    endtask

    task automatic bus_write(input logic [1:0] a, input logic [31:0] d);
        @(negedge sys_clk);
        cs    = 1'b1;
        wr    = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge sys_clk);
        while (!wrn) @(negedge sys_clk);
        cs = 1'b0;
        wr = 1'b0;
    endtask

    task automatic bus_read(input logic [1:0] a, output logic [31:0] d);
        @(negedge sys_clk);
        cs   = 1'b1;
        wr   = 1'b0;
        addr = a;
        @(negedge sys_clk);
        while (!wrn) @(negedge sys_clk);
        d  = rdata;
        cs = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Keyboard model
    ////////////////////////////////////////////////////////////

    task automatic dev_send(input logic [7:0] b, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, parity_of(b) ^ bad_parity, b, 1'b0};
        @(negedge sys_clk);
        for (int i = 0; i < 11; i++) begin
            // Data moves while the clock is high
            dev_dat = frame[i];
            #(QUARTER_NS);
            dev_clk = 1'b0;
            #(HALF_NS);
            dev_clk = 1'b1;
            #(QUARTER_NS);
        end
        dev_dat = 1'b1;
        #(BIT_NS);
    endtask

    task automatic dev_receive(input logic give_ack, output logic [7:0] data,
                               output logic par, output logic stop, output time end_t);
        logic [9:0] bits;
        wait (clk_oe == 1'b1);
        wait (clk_oe == 1'b0);
        @(negedge sys_clk);
        expect_eq("kbd_dat at request-to-send", {31'd0, kbd_dat}, 32'd0);
        #(HALF_NS);
        // Host data is read just before each rising clock
        for (int i = 0; i < 10; i++) begin
            dev_clk = 1'b0;
            #(HALF_NS);
            bits[i] = kbd_dat;
            dev_clk = 1'b1;
            #(HALF_NS);
        end
        if (give_ack) begin
            dev_dat = 1'b0;
        end
        #(QUARTER_NS);
        dev_clk = 1'b0;
        #(HALF_NS);
        dev_clk = 1'b1;
        end_t = $time;
        #(QUARTER_NS);
        dev_dat = 1'b1;
        #(QUARTER_NS);
        data = bits[7:0];
        par  = bits[8];
        stop = bits[9];
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        logic [31:0] rd;
        int          e0;
        e0 = n_errors;
        expect_eq("irq", {31'd0, irq}, 32'd0);
        expect_eq("kbd_clk_oe", {31'd0, clk_oe}, 32'd0);
        expect_eq("kbd_dat_oe", {31'd0, dat_oe}, 32'd0);
        expect_eq("waitrequest_n", {31'd0, wrn}, 32'd0);
        bus_read(A_STAT, rd);
        expect_eq("status", rd, 32'd0);
        bus_read(A_CTRL, rd);
        expect_eq("control", rd, 32'd0);
        report_test("reset state", e0);
    endtask

    task automatic send_with_ack();
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic [7:0]  g1;
        logic [7:0]  g2;
        logic        p1;
        logic        p2;
        logic        s1;
        logic        s2;
        time         t1;
        time         t2;
        time         w2_done;
        logic [31:0] rd;
        int          e0;
        e0 = n_errors;
        b1 = rand_byte();
        b2 = rand_byte();
        fork
            begin
                dev_receive(1'b1, g1, p1, s1, t1);
                dev_receive(1'b1, g2, p2, s2, t2);
            end
            begin
                bus_write(A_DATA, {24'd0, b1});
                bus_read(A_STAT, rd);
                expect_eq("status during frame", rd, ST_BUSY);
                // Held off by the busy transmitter
                bus_write(A_DATA, {24'd0, b2});
                w2_done = $time;
            end
        join
        expect_eq("first byte seen by device", {24'd0, g1}, {24'd0, b1});
        expect_eq("first parity", {31'd0, p1}, {31'd0, parity_of(b1)});
        expect_eq("first stop", {31'd0, s1}, 32'd1);
        expect_eq("second byte seen by device", {24'd0, g2}, {24'd0, b2});
        expect_eq("second parity", {31'd0, p2}, {31'd0, parity_of(b2)});
        expect_eq("second stop", {31'd0, s2}, 32'd1);
        expect_eq("second write after first frame", 32'(w2_done > t1), 32'd1);
        bus_read(A_STAT, rd);
        expect_eq("status after frames", rd, 32'd0);
        report_test("transmit with acknowledge", e0);
    endtask

    task automatic send_without_ack();
        logic [7:0]  b;
        logic [7:0]  g;
        logic        p;
        logic        s;
        time         t;
        logic [31:0] rd;
        int          e0;
        e0 = n_errors;
        b = rand_byte();
        bus_write(A_DATA, {24'd0, b});
        dev_receive(1'b0, g, p, s, t);
        expect_eq("byte seen by device", {24'd0, g}, {24'd0, b});
        expect_eq("parity", {31'd0, p}, {31'd0, parity_of(b)});
        expect_eq("stop", {31'd0, s}, 32'd1);
        bus_read(A_STAT, rd);
        expect_eq("status after missing ack", rd, ST_ACK);
        bus_write(A_STAT, ST_ACK);
        bus_read(A_STAT, rd);
        expect_eq("status after ack clear", rd, 32'd0);
        report_test("transmit without acknowledge", e0);
    endtask

    task automatic receive_bytes();
        logic [7:0]  sent [3];
        logic [31:0] rd;
        int          e0;
        e0 = n_errors;
        bus_write(A_CTRL, 32'd1);
        bus_read(A_CTRL, rd);
        expect_eq("control", rd, 32'd1);
        expect_eq("irq before receive", {31'd0, irq}, 32'd0);
        for (int i = 0; i < 3; i++) begin
            sent[i] = rand_byte();
            dev_send(sent[i], 1'b0);
        end
        expect_eq("irq after receive", {31'd0, irq}, 32'd1);
        for (int i = 0; i < 3; i++) begin
            bus_read(A_DATA, rd);
            expect_eq("data", rd, {24'd0, sent[i]});
        end
        // Pop lands one cycle after the read completes
        @(negedge sys_clk);
        expect_eq("irq after drain", {31'd0, irq}, 32'd0);
        bus_write(A_CTRL, 32'd0);
        report_test("receive", e0);
    endtask

    task automatic reject_bad_parity();
        logic [31:0] rd;
        int          e0;
        e0 = n_errors;
        dev_send(rand_byte(), 1'b1);
        bus_read(A_STAT, rd);
        expect_eq("status after bad parity", rd, ST_PAR);
        bus_write(A_STAT, ST_PAR);
        bus_read(A_STAT, rd);
        expect_eq("status after parity clear", rd, 32'd0);
        report_test("parity error", e0);
    endtask

    task automatic fill_past_depth();
        logic [7:0]  q [RX_DEPTH + 1];
        logic [31:0] rd;
        int          e0;
        e0 = n_errors;
        for (int i = 0; i < RX_DEPTH + 1; i++) begin
            q[i] = rand_byte();
            dev_send(q[i], 1'b0);
        end
        bus_read(A_STAT, rd);
        expect_eq("status when full", rd, ST_RXV | ST_OVF);
        for (int i = 0; i < RX_DEPTH; i++) begin
            bus_read(A_DATA, rd);
            expect_eq("data", rd, {24'd0, q[i]});
        end
        bus_read(A_DATA, rd);
        expect_eq("data when empty", rd, 32'd0);
        bus_read(A_STAT, rd);
        expect_eq("status after drain", rd, ST_OVF);
        bus_write(A_STAT, ST_OVF);
        bus_read(A_STAT, rd);
        expect_eq("status after overflow clear", rd, 32'd0);
        report_test("overflow", e0);
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        arst_n    = 1'b0;
        cs        = 1'b0;
        wr        = 1'b0;
        addr      = 2'd0;
        wdata     = 32'd0;
        dev_clk   = 1'b1;
        dev_dat   = 1'b1;
        rng_state = 32'heded_da8b;
        n_errors  = 0;
        n_checks  = 0;
        n_tests   = 0;
        repeat (10) @(negedge sys_clk);
        arst_n = 1'b1;
        repeat (5) @(negedge sys_clk);
        check_reset_state();
        send_with_ack();
        send_without_ack();
        receive_bytes();
        reject_bad_parity();
        fill_past_depth();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
